// File: hdl/rv32_isa_pkg.sv
package rv32_isa_pkg;

    // Major opcodes of the memory instructions
    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } opcode_t;

    // Load widths with bit 2 selecting zero extension
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

endpackage : rv32_isa_pkg

// File: hdl/lsu_pkg.sv
package lsu_pkg;

    localparam int XLEN           = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int BE_WIDTH       = BYTES_PER_WORD;
    localparam int BYTE_OFS_WIDTH = 2;   // Lane select bits of the address

    // Enable patterns for lane 0
    localparam logic [BE_WIDTH-1:0] BE_BYTE = 4'b0001;
    localparam logic [BE_WIDTH-1:0] BE_HALF = 4'b0011;
    localparam logic [BE_WIDTH-1:0] BE_WORD = 4'b1111;

    // Access FSM encoding
    localparam int STATE_WIDTH = 2;
    localparam logic [STATE_WIDTH-1:0] ST_IDLE    = 2'd0;
    localparam logic [STATE_WIDTH-1:0] ST_ACCESS  = 2'd1;
    localparam logic [STATE_WIDTH-1:0] ST_RESPOND = 2'd2;

    typedef logic [XLEN-1:0]     word_t;
    typedef logic [BE_WIDTH-1:0] be_t;

    // One memory word seen as byte lanes or as halfword lanes
    typedef union packed {
        logic [BYTES_PER_WORD-1:0][7:0]       bytes;
        logic [BYTES_PER_WORD/2-1:0][15:0]    halves;
    } mem_word_u;

endpackage : lsu_pkg

// File: hdl/access_decode.sv
`timescale 1ns/1ps

module access_decode (
    input  logic                                is_store_i,
    input  logic [2:0]                          funct3_i,
    input  lsu_pkg::word_t                      base_i,
    input  lsu_pkg::word_t                      offset_i,
    input  lsu_pkg::word_t                      store_data_i,
    output lsu_pkg::word_t                      address_o,
    output logic [lsu_pkg::BYTE_OFS_WIDTH-1:0]  byte_ofs_o,
    output lsu_pkg::be_t                        byte_enable_o,
    output lsu_pkg::word_t                      wdata_o,
    output logic                                trap_o
);

    lsu_pkg::word_t                      eff_addr;
    logic [lsu_pkg::BYTE_OFS_WIDTH-1:0]  ofs;
    lsu_pkg::be_t                        size_be;
    logic                                misaligned;
    logic                                bad_funct3;
    lsu_pkg::mem_word_u                  lanes;

    assign eff_addr   = base_i + offset_i;
    assign ofs        = eff_addr[lsu_pkg::BYTE_OFS_WIDTH-1:0];
    assign byte_ofs_o = ofs;
    assign address_o  = {eff_addr[lsu_pkg::XLEN-1:lsu_pkg::BYTE_OFS_WIDTH],
                         {lsu_pkg::BYTE_OFS_WIDTH{1'b0}}};

    // Access size and alignment check
    always_comb begin
        size_be    = lsu_pkg::BE_WORD;
        misaligned = 1'b0;
        bad_funct3 = 1'b0;
        if (is_store_i) begin
            case (rv32_isa_pkg::store_funct3_t'(funct3_i))
                rv32_isa_pkg::sb: size_be = lsu_pkg::BE_BYTE;
                rv32_isa_pkg::sh: begin
                    size_be    = lsu_pkg::BE_HALF;
                    misaligned = ofs[0];
                end
                rv32_isa_pkg::sw: misaligned = |ofs;
                default:          bad_funct3 = 1'b1;
            endcase
        end else begin
            case (rv32_isa_pkg::load_funct3_t'(funct3_i))
                rv32_isa_pkg::lb, rv32_isa_pkg::lbu: size_be = lsu_pkg::BE_BYTE;
                rv32_isa_pkg::lh, rv32_isa_pkg::lhu: begin
                    size_be    = lsu_pkg::BE_HALF;
                    misaligned = ofs[0];
                end
                rv32_isa_pkg::lw: misaligned = |ofs;
                default:          bad_funct3 = 1'b1;
            endcase
        end
    end

    assign trap_o = misaligned | bad_funct3;

    // Move the low store data into the addressed lane
    always_comb begin
        lanes = '0;
        case (size_be)
            lsu_pkg::BE_BYTE: lanes.bytes[ofs]     = store_data_i[7:0];
            lsu_pkg::BE_HALF: lanes.halves[ofs[1]] = store_data_i[15:0];
            default:          lanes                = store_data_i;
        endcase
    end

    assign wdata_o = lanes;

    // Loads and trapped stores write nothing
    assign byte_enable_o = (is_store_i && !trap_o) ? (size_be << ofs) : '0;

endmodule : access_decode

// File: hdl/load_extract.sv
`timescale 1ns/1ps

module load_extract (
    input  logic [2:0]                          funct3_i,
    input  logic [lsu_pkg::BYTE_OFS_WIDTH-1:0]  byte_ofs_i,
    input  lsu_pkg::word_t                      mem_rdata_i,
    output lsu_pkg::word_t                      load_data_o
);

    lsu_pkg::mem_word_u  rdata_u;
    logic [7:0]          byte_sel;
    logic [15:0]         half_sel;

    assign rdata_u  = mem_rdata_i;
    assign byte_sel = rdata_u.bytes[byte_ofs_i];
    assign half_sel = rdata_u.halves[byte_ofs_i[1]];   // Offset bit 0 is zero here

    always_comb begin
        case (rv32_isa_pkg::load_funct3_t'(funct3_i))
            rv32_isa_pkg::lb: begin
                load_data_o = {{(lsu_pkg::XLEN-8){byte_sel[7]}}, byte_sel};
            end
            rv32_isa_pkg::lh: begin
                load_data_o = {{(lsu_pkg::XLEN-16){half_sel[15]}}, half_sel};
            end
            rv32_isa_pkg::lbu: begin
                load_data_o = {{(lsu_pkg::XLEN-8){1'b0}}, byte_sel};
            end
            rv32_isa_pkg::lhu: begin
                load_data_o = {{(lsu_pkg::XLEN-16){1'b0}}, half_sel};
            end
            rv32_isa_pkg::lw: load_data_o = mem_rdata_i;
            default:          load_data_o = '0;
        endcase
    end

endmodule : load_extract

// File: hdl/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                req_valid_i,
    input  logic                                req_is_store_i,
    input  logic [2:0]                          req_funct3_i,
    input  lsu_pkg::word_t                      address_i,
    input  logic [lsu_pkg::BYTE_OFS_WIDTH-1:0]  byte_ofs_i,
    input  lsu_pkg::be_t                        byte_enable_i,
    input  lsu_pkg::word_t                      wdata_i,
    input  logic                                trap_i,
    input  logic                                mem_resp_i,
    input  lsu_pkg::word_t                      load_data_i,
    output logic                                req_ready_o,
    output logic [2:0]                          funct3_o,
    output logic [lsu_pkg::BYTE_OFS_WIDTH-1:0]  byte_ofs_o,
    output logic                                mem_read_o,
    output logic                                mem_write_o,
    output lsu_pkg::word_t                      mem_address_o,
    output lsu_pkg::be_t                        mem_byte_enable_o,
    output lsu_pkg::word_t                      mem_wdata_o,
    output logic                                rsp_valid_o,
    output lsu_pkg::word_t                      rsp_load_data_o,
    output logic                                rsp_trap_o
);

    logic [lsu_pkg::STATE_WIDTH-1:0]     state_q;
    logic [lsu_pkg::STATE_WIDTH-1:0]     state_d;
    logic                                accept;
    logic                                in_access;

    // Held request
    logic                                is_store_q;
    logic                                trap_q;
    logic [2:0]                          funct3_q;
    logic [lsu_pkg::BYTE_OFS_WIDTH-1:0]  byte_ofs_q;
    lsu_pkg::word_t                      address_q;
    lsu_pkg::be_t                        byte_enable_q;
    lsu_pkg::word_t                      wdata_q;
    lsu_pkg::word_t                      rsp_data_q;

    assign req_ready_o = (state_q == lsu_pkg::ST_IDLE);
    assign accept      = req_valid_i && req_ready_o;
    assign in_access   = (state_q == lsu_pkg::ST_ACCESS);

    always_comb begin
        state_d = state_q;
        case (state_q)
            lsu_pkg::ST_IDLE: begin
                if (accept) begin
                    state_d = trap_i ? lsu_pkg::ST_RESPOND : lsu_pkg::ST_ACCESS;
                end
            end
            lsu_pkg::ST_ACCESS: begin
                if (mem_resp_i) begin
                    state_d = lsu_pkg::ST_RESPOND;
                end
            end
            lsu_pkg::ST_RESPOND: state_d = lsu_pkg::ST_IDLE;   // Single pulse
            default:             state_d = lsu_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= lsu_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            is_store_q    <= req_is_store_i;
            trap_q        <= trap_i;
            funct3_q      <= req_funct3_i;
            byte_ofs_q    <= byte_ofs_i;
            address_q     <= address_i;
            byte_enable_q <= byte_enable_i;
            wdata_q       <= wdata_i;
            rsp_data_q    <= '0;   // Stays zero for stores and traps
        end else if (in_access && mem_resp_i && !is_store_q) begin
            rsp_data_q    <= load_data_i;
        end
    end

    // Strobes held for the whole access
    assign mem_read_o        = in_access && !is_store_q;
    assign mem_write_o       = in_access && is_store_q;
    assign mem_address_o     = address_q;
    assign mem_byte_enable_o = byte_enable_q;
    assign mem_wdata_o       = wdata_q;

    // To load_extract
    assign funct3_o   = funct3_q;
    assign byte_ofs_o = byte_ofs_q;

    assign rsp_valid_o     = (state_q == lsu_pkg::ST_RESPOND);
    assign rsp_load_data_o = rsp_data_q;
    assign rsp_trap_o      = trap_q;

endmodule : lsu_ctrl

// File: hdl/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic            clk,
    input  logic            reset_i,

    // Request
    input  logic            req_valid_i,
    input  logic            req_is_store_i,
    input  logic [2:0]      req_funct3_i,
    input  lsu_pkg::word_t  req_base_i,
    input  lsu_pkg::word_t  req_offset_i,
    input  lsu_pkg::word_t  req_store_data_i,
    output logic            req_ready_o,

    // Result
    output logic            rsp_valid_o,
    output lsu_pkg::word_t  rsp_load_data_o,
    output logic            rsp_trap_o,

    // Data memory
    output logic            mem_read_o,
    output logic            mem_write_o,
    output lsu_pkg::word_t  mem_address_o,
    output lsu_pkg::be_t    mem_byte_enable_o,
    output lsu_pkg::word_t  mem_wdata_o,
    input  lsu_pkg::word_t  mem_rdata_i,
    input  logic            mem_resp_i
);

    lsu_pkg::word_t                      dec_address;
    logic [lsu_pkg::BYTE_OFS_WIDTH-1:0]  dec_byte_ofs;
    lsu_pkg::be_t                        dec_byte_enable;
    lsu_pkg::word_t                      dec_wdata;
    logic                                dec_trap;
    logic [2:0]                          held_funct3;
    logic [lsu_pkg::BYTE_OFS_WIDTH-1:0]  held_byte_ofs;
    lsu_pkg::word_t                      load_data;

    access_decode access_decode_i (
        .is_store_i    (req_is_store_i),
        .funct3_i      (req_funct3_i),
        .base_i        (req_base_i),
        .offset_i      (req_offset_i),
        .store_data_i  (req_store_data_i),
        .address_o     (dec_address),
        .byte_ofs_o    (dec_byte_ofs),
        .byte_enable_o (dec_byte_enable),
        .wdata_o       (dec_wdata),
        .trap_o        (dec_trap)
    );

    lsu_ctrl lsu_ctrl_i (
        .clk               (clk),
        .reset_i           (reset_i),
        .req_valid_i       (req_valid_i),
        .req_is_store_i    (req_is_store_i),
        .req_funct3_i      (req_funct3_i),
        .address_i         (dec_address),
        .byte_ofs_i        (dec_byte_ofs),
        .byte_enable_i     (dec_byte_enable),
        .wdata_i           (dec_wdata),
        .trap_i            (dec_trap),
        .mem_resp_i        (mem_resp_i),
        .load_data_i       (load_data),
        .req_ready_o       (req_ready_o),
        .funct3_o          (held_funct3),
        .byte_ofs_o        (held_byte_ofs),
        .mem_read_o        (mem_read_o),
        .mem_write_o       (mem_write_o),
        .mem_address_o     (mem_address_o),
        .mem_byte_enable_o (mem_byte_enable_o),
        .mem_wdata_o       (mem_wdata_o),
        .rsp_valid_o       (rsp_valid_o),
        .rsp_load_data_o   (rsp_load_data_o),
        .rsp_trap_o        (rsp_trap_o)
    );

    load_extract load_extract_i (
        .funct3_i    (held_funct3),
        .byte_ofs_i  (held_byte_ofs),
        .mem_rdata_i (mem_rdata_i),
        .load_data_o (load_data)
    );

endmodule : lsu_top

// File: verification/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

    localparam int    RESET_CYCLES    = 10;
    localparam int    CYCLES_PER_TEST = 16;
    localparam int    MEM_WORDS       = 16;
    localparam string TEST_FILE       = "verification/lsu_tests.txt";

    logic            clk;
    logic            reset_i;
    logic            req_valid_i;
    logic            req_is_store_i;
    logic [2:0]      req_funct3_i;
    lsu_pkg::word_t  req_base_i;
    lsu_pkg::word_t  req_offset_i;
    lsu_pkg::word_t  req_store_data_i;
    logic            req_ready_o;
    logic            rsp_valid_o;
    lsu_pkg::word_t  rsp_load_data_o;
    logic            rsp_trap_o;
    logic            mem_read_o;
    logic            mem_write_o;
    lsu_pkg::word_t  mem_address_o;
    lsu_pkg::be_t    mem_byte_enable_o;
    lsu_pkg::word_t  mem_wdata_o;
    lsu_pkg::word_t  mem_rdata_i;
    logic            mem_resp_i;

    lsu_pkg::word_t  mem [MEM_WORDS];
    logic [7:0]      lfsr_q;
    logic            mem_busy;
    int              mem_delay;

    // One entry per test line
    logic [6:0]      t_op [$];
    logic [2:0]      t_funct3 [$];
    logic [31:0]     t_base [$];
    logic [31:0]     t_offset [$];
    logic [31:0]     t_store_data [$];
    logic [3:0]      t_be [$];
    logic [31:0]     t_addr [$];
    logic [31:0]     t_load_data [$];
    logic            t_trap [$];

    int              errors;
    int              failed_tests;
    int              cycle_count;
    int              cycle_limit;

    lsu_top lsu_top_i (
        .clk               (clk),
        .reset_i           (reset_i),
        .req_valid_i       (req_valid_i),
        .req_is_store_i    (req_is_store_i),
        .req_funct3_i      (req_funct3_i),
        .req_base_i        (req_base_i),
        .req_offset_i      (req_offset_i),
        .req_store_data_i  (req_store_data_i),
        .req_ready_o       (req_ready_o),
        .rsp_valid_o       (rsp_valid_o),
        .rsp_load_data_o   (rsp_load_data_o),
        .rsp_trap_o        (rsp_trap_o),
        .mem_read_o        (mem_read_o),
        .mem_write_o       (mem_write_o),
        .mem_address_o     (mem_address_o),
        .mem_byte_enable_o (mem_byte_enable_o),
        .mem_wdata_o       (mem_wdata_o),
        .mem_rdata_i       (mem_rdata_i),
        .mem_resp_i        (mem_resp_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 8, 6, 5, 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
    endfunction

    task automatic random_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value  = (value << 1) | lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic serve_access();
        int idx;
        idx = mem_address_o[5:2];
        if (mem_write_o) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_byte_enable_o[b]) begin
                    mem[idx][8*b +: 8] = mem_wdata_o[8*b +: 8];
                end
            end
        end
        mem_rdata_i = mem[idx];
    endtask

    // Memory model that responds 0 to 3 cycles after the strobe rises
    always @(negedge clk) begin
        if (reset_i) begin
            mem_resp_i  = 1'b0;
            mem_rdata_i = '0;
            mem_busy    = 1'b0;
        end else if (mem_resp_i) begin
            mem_resp_i  = 1'b0;
            mem_rdata_i = '0;
        end else if (mem_read_o || mem_write_o) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                random_bits(2, mem_delay);
            end
            if (mem_delay == 0) begin
                serve_access();
                mem_resp_i = 1'b1;
                mem_busy   = 1'b0;
            end else begin
                mem_delay--;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic load_tests();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] op, f3, base, ofs, sdata, be, addr, ldata, trap;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the test file %s", TEST_FILE);
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                     op, f3, base, ofs, sdata, be, addr, ldata, trap);
                    if (fields == 9) begin
                        t_op.push_back(op[6:0]);
                        t_funct3.push_back(f3[2:0]);
                        t_base.push_back(base);
                        t_offset.push_back(ofs);
                        t_store_data.push_back(sdata);
                        t_be.push_back(be[3:0]);
                        t_addr.push_back(addr);
                        t_load_data.push_back(ldata);
                        t_trap.push_back(trap[0]);
                    end else if (fields > 0) begin
                        $display("Malformed line in the test file: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Called on a falling edge with the unit idle
    task automatic run_test(input int n);
        lsu_pkg::word_t  seen_addr;
        lsu_pkg::be_t    seen_be;
        lsu_pkg::word_t  seen_wdata;
        logic            is_store;
        int              strobe_cycles;
        int              wait_cycles;
        int              errors_before;
        string           kind;
        errors_before = errors;
        is_store      = (t_op[n] == rv32_isa_pkg::op_store);
        kind          = is_store ? "store" : "load";
        strobe_cycles = 0;
        wait_cycles   = 0;
        seen_addr     = '0;
        seen_be       = '0;
        seen_wdata    = '0;
        if (t_op[n] != rv32_isa_pkg::op_store && t_op[n] != rv32_isa_pkg::op_load) begin
            $display("Test line %0d has an unknown opcode %h", n, t_op[n]);
            errors++;
        end

        check_value("req_ready_o before request", req_ready_o, 1'b1);
        req_valid_i      = 1'b1;
        req_is_store_i   = is_store;
        req_funct3_i     = t_funct3[n];
        req_base_i       = t_base[n];
        req_offset_i     = t_offset[n];
        req_store_data_i = t_store_data[n];
        @(negedge clk);
        req_valid_i = 1'b0;

        while (!rsp_valid_o) begin
            check_value("req_ready_o during access", req_ready_o, 1'b0);
            if (mem_read_o || mem_write_o) begin
                check_value("mem_read_o", mem_read_o, !is_store);
                check_value("mem_write_o", mem_write_o, is_store);
                if (strobe_cycles == 0) begin
                    seen_addr  = mem_address_o;
                    seen_be    = mem_byte_enable_o;
                    seen_wdata = mem_wdata_o;
                end else begin
                    check_value("mem_address_o held", mem_address_o, seen_addr);
                    check_value("mem_byte_enable_o held", mem_byte_enable_o, seen_be);
                    check_value("mem_wdata_o held", mem_wdata_o, seen_wdata);
                end
                strobe_cycles++;
            end
            wait_cycles++;
            @(negedge clk);
        end

        check_value("rsp_trap_o", rsp_trap_o, t_trap[n]);
        check_value("rsp_load_data_o", rsp_load_data_o, t_load_data[n]);
        check_value("req_ready_o with rsp_valid_o", req_ready_o, 1'b0);
        if (t_trap[n]) begin
            check_value("strobe cycles on a trap", strobe_cycles, 0);
            check_value("cycles before trap response", wait_cycles, 0);
        end else begin
            check_value("strobe seen", strobe_cycles > 0, 1'b1);
            check_value("mem_address_o", seen_addr, t_addr[n]);
            check_value("mem_byte_enable_o", seen_be, t_be[n]);
        end

        @(negedge clk);
        check_value("rsp_valid_o after pulse", rsp_valid_o, 1'b0);
        check_value("req_ready_o after response", req_ready_o, 1'b1);

        if (errors != errors_before) begin
            failed_tests++;
        end
        $display("test %0d: %s funct3 %0d address %h: %s", n, kind, t_funct3[n],
                 t_addr[n], (errors == errors_before) ? "ok" : "FAILED");
    endtask

    initial begin
        reset_i          = 1'b1;
        req_valid_i      = 1'b0;
        req_is_store_i   = 1'b0;
        req_funct3_i     = '0;
        req_base_i       = '0;
        req_offset_i     = '0;
        req_store_data_i = '0;
        mem_rdata_i      = '0;
        mem_resp_i       = 1'b0;
        errors           = 0;
        failed_tests     = 0;
        cycle_count      = 0;
        lfsr_q           = 8'd85;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end

        load_tests();
        cycle_limit = t_op.size() * CYCLES_PER_TEST + RESET_CYCLES;

        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;

        for (int n = 0; n < t_op.size(); n++) begin
            run_test(n);
        end

        $display("%0d tests run, %0d failed, %0d mismatches",
                 t_op.size(), failed_tests, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : lsu_tb

// File: build.f
hdl/rv32_isa_pkg.sv
hdl/lsu_pkg.sv
hdl/access_decode.sv
hdl/load_extract.sv
hdl/lsu_ctrl.sv
hdl/lsu_top.sv
verification/lsu_tb.sv

// File: verification/lsu_tests.txt
# opcode funct3 base offset store_data (all hex)
# then expected byte_enable word_address load_data trap
23 2 00000000 00000008 deadbeef f 00000008 00000000 0
03 2 00000008 00000000 00000000 0 00000008 deadbeef 0
23 2 00000110 fffffff4 12345678 f 00000104 00000000 0
03 2 00000100 00000004 00000000 0 00000104 12345678 0
23 0 0000000c 00000000 000000aa 1 0000000c 00000000 0
23 0 0000000c 00000001 ffffffbb 2 0000000c 00000000 0
23 0 0000000c 00000002 123456cc 4 0000000c 00000000 0
23 0 0000000c 00000003 000000dd 8 0000000c 00000000 0
03 2 0000000c 00000000 00000000 0 0000000c ddccbbaa 0
23 1 00000010 00000000 ffff8001 3 00000010 00000000 0
23 1 00000010 00000002 00007f80 c 00000010 00000000 0
03 2 00000010 00000000 00000000 0 00000010 7f808001 0
03 0 0000000c 00000000 00000000 0 0000000c ffffffaa 0
03 4 0000000c 00000001 00000000 0 0000000c 000000bb 0
03 0 0000000c 00000002 00000000 0 0000000c ffffffcc 0
03 4 0000000c 00000003 00000000 0 0000000c 000000dd 0
03 0 00000010 00000003 00000000 0 00000010 0000007f 0
03 0 00000010 00000001 00000000 0 00000010 ffffff80 0
03 1 00000010 00000000 00000000 0 00000010 ffff8001 0
03 5 00000010 00000000 00000000 0 00000010 00008001 0
03 1 00000010 00000002 00000000 0 00000010 00007f80 0
03 5 0000000c 00000002 00000000 0 0000000c 0000ddcc 0
03 2 00000008 00000001 00000000 0 00000008 00000000 1
23 2 00000008 00000002 11111111 0 00000008 00000000 1
03 1 00000010 00000003 00000000 0 00000010 00000000 1
23 1 0000000c 00000001 00002222 0 0000000c 00000000 1
03 3 00000000 00000010 00000000 0 00000010 00000000 1
23 4 00000000 0000000c 33333333 0 0000000c 00000000 1
03 6 00000008 00000000 00000000 0 00000008 00000000 1
03 2 00000008 00000000 00000000 0 00000008 deadbeef 0
03 2 0000000c 00000000 00000000 0 0000000c ddccbbaa 0
